/* hw/pongPkg.sv */
`default_nettype none

package pongPkg;

	//////////////////////////////////////////////////
	// Widths with a meaning
	//////////////////////////////////////////////////
	typedef logic [9:0] coordT;	// Screen coordinate, x or y
	typedef logic [7:0] pixelT;	// RRR GGG BB
	typedef logic [7:0] potT;	// Raw pot level
	typedef logic [3:0] scoreT;	// One digit per player

	typedef enum logic [1:0]
	{
		noPlayer,
		leftPlayer,
		rightPlayer
	} playerT;

	// Game FSM, one state per game tick
	typedef enum logic [2:0]
	{
		sIdle,
		sServeWait,
		sPaddles,
		sBall,
		sCheck,
		sScore,
		sWin
	} gameStateT;

	// Everything the renderer needs for one frame
	typedef struct packed
	{
		coordT ballX;	// Top left of ball
		coordT ballY;
		coordT leftPaddleY;
		coordT rightPaddleY;
		scoreT leftScore;
		scoreT rightScore;
		logic playing;	// Low while idle, screen stays dark
		pixelT colour;
	} sceneT;

	// Raster timing, 640x480 at one pixel per clock
	localparam int screenW = 640;
	localparam int screenH = 480;
	localparam int hTotal = 800;
	localparam int hSyncStart = 656;
	localparam int hSyncLen = 96;
	localparam int vTotal = 525;
	localparam int vSyncStart = 490;
	localparam int vSyncLen = 2;

	// Object sizes and fixed columns
	localparam int ballSize = 10;
	localparam int paddleW = 10;
	localparam int paddleH = 50;
	localparam int leftPaddleX = 40;
	localparam int rightPaddleX = 600;

	// Pot to paddle mapping
	localparam int potDeadzone = 41;
	localparam int paddleMaxY = 430;	// screenH - paddleH

	// Serve and play limits
	localparam int serveX = 315;
	localparam int serveY = 235;
	localparam int serveSpeed = 1;
	localparam int startSpeed = 2;
	localparam int goalRightX = 630;
	localparam int floorY = 470;
	localparam int winScore = 9;

	// Centre line and score digits
	localparam int borderX = 319;
	localparam int borderW = 2;
	localparam int dashLen = 10;
	localparam int leftDigitX = 255;
	localparam int rightDigitX = 345;
	localparam int digitY = 10;
	localparam int digitBar = 8;	// Cell size of the 3x5 glyph

endpackage

`default_nettype wire

/* hw/vgaSyncGen.sv */
`timescale 1ns/100ps
`default_nettype none

module vgaSyncGen import pongPkg::*;
(
	input wire DIV_CLK,
	input wire reset,
	output coordT pixelX,
	output coordT pixelY,
	output logic inDisplay,
	output logic hSyncRaw,
	output logic vSyncRaw
);

	coordT hCount;	// Pixel within line, 0..799
	coordT vCount;	// Line within frame, 0..524

	//////////////////////////////////////////////////
	// Raster counters
	//////////////////////////////////////////////////
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			hCount <= '0;
			vCount <= '0;
		end
		else if (hCount == coordT'(hTotal - 1))
		begin
			hCount <= '0;	// End of line
			if (vCount == coordT'(vTotal - 1))
				vCount <= '0;	// End of frame
			else
				vCount <= vCount + coordT'(1);
		end
		else
			hCount <= hCount + coordT'(1);
	end

	assign pixelX = hCount;
	assign pixelY = vCount;

	// Sync pulses, active low
	assign hSyncRaw = !((hCount >= coordT'(hSyncStart)) &&
		(hCount < coordT'(hSyncStart + hSyncLen)));
	assign vSyncRaw = !((vCount >= coordT'(vSyncStart)) &&
		(vCount < coordT'(vSyncStart + vSyncLen)));

	// Visible area only
	assign inDisplay = (hCount < coordT'(screenW)) && (vCount < coordT'(screenH));

endmodule

`default_nettype wire

/* hw/rectHit.sv */
`timescale 1ns/100ps
`default_nettype none

module rectHit import pongPkg::*;
(
	input wire coordT pointX,
	input wire coordT pointY,
	input wire coordT rectX,
	input wire coordT rectY,
	input wire coordT rectW,
	input wire coordT rectH,
	output logic hit
);

	logic [10:0] rightEdge;	// Exclusive, one bit wider so it cannot wrap
	logic [10:0] bottomEdge;	// Exclusive

	assign rightEdge = {1'b0, rectX} + {1'b0, rectW};
	assign bottomEdge = {1'b0, rectY} + {1'b0, rectH};

	// Half-open box, same rule on screen and in play
	assign hit = (pointX >= rectX) && ({1'b0, pointX} < rightEdge) &&
		(pointY >= rectY) && ({1'b0, pointY} < bottomEdge);

endmodule

`default_nettype wire

/* hw/scoreDigit.sv */
`timescale 1ns/100ps
`default_nettype none

module scoreDigit import pongPkg::*;
(
	input wire coordT pixelX,
	input wire coordT pixelY,
	input wire coordT originX,
	input wire scoreT value,
	output logic hit
);

	logic [10:0] boxRight;	// Glyph is 3 cells wide
	logic [10:0] boxBottom;	// and 5 cells tall
	logic inBox;
	coordT cellX;	// Column 0..2 inside glyph
	coordT cellY;	// Row 0..4
	logic [6:0] seg;	// a b c d e f g, active high
	logic leftCol, rightCol, topRow, midRow, botRow;
	logic upperHalf, lowerHalf;

	assign boxRight = {1'b0, originX} + 11'(3 * digitBar);
	assign boxBottom = 11'(digitY + 5 * digitBar);
	assign inBox = (pixelX >= originX) && ({1'b0, pixelX} < boxRight) &&
		(pixelY >= coordT'(digitY)) && ({1'b0, pixelY} < boxBottom);

	// Cell index, only meaningful inside the box
	assign cellX = coordT'((pixelX - originX) / digitBar);
	assign cellY = coordT'((pixelY - coordT'(digitY)) / digitBar);

	//////////////////////////////////////////////////
	// Value to segments
	//////////////////////////////////////////////////
	always_comb
	begin
		case (value)
			4'd0: seg = 7'b1111110;
			4'd1: seg = 7'b0110000;
			4'd2: seg = 7'b1101101;
			4'd3: seg = 7'b1111001;
			4'd4: seg = 7'b0110011;
			4'd5: seg = 7'b1011011;
			4'd6: seg = 7'b1011111;
			4'd7: seg = 7'b1110000;
			4'd8: seg = 7'b1111111;
			4'd9: seg = 7'b1111011;
			default: seg = 7'b0000000;	// Blank above 9
		endcase
	end

	assign leftCol = (cellX == coordT'(0));
	assign rightCol = (cellX == coordT'(2));
	assign topRow = (cellY == coordT'(0));
	assign midRow = (cellY == coordT'(2));
	assign botRow = (cellY == coordT'(4));
	assign upperHalf = (cellY <= coordT'(2));	// Side bars share the middle row
	assign lowerHalf = (cellY >= coordT'(2));

	// Light cells covered by an active segment
	assign hit = inBox && (
		(seg[6] && topRow) ||	// a
		(seg[5] && rightCol && upperHalf) ||	// b
		(seg[4] && rightCol && lowerHalf) ||	// c
		(seg[3] && botRow) ||	// d
		(seg[2] && leftCol && lowerHalf) ||	// e
		(seg[1] && leftCol && upperHalf) ||	// f
		(seg[0] && midRow));	// g

endmodule

`default_nettype wire

/* hw/gameController.sv */
`timescale 1ns/100ps
`default_nettype none

module gameController import pongPkg::*;
#(
	parameter int tickDiv = 65536,	// Clocks per game tick
	parameter int serveDelay = 400,	// Ticks before a serve
	parameter int winHold = 4000	// Ticks the result stays up
)
(
	input wire DIV_CLK,
	input wire reset,
	input wire potT leftPot,
	input wire potT rightPot,
	input wire startBtn,
	input wire pixelT colourSw,
	output sceneT scene,
	output scoreT leftScore,
	output scoreT rightScore,
	output playerT winner
);

	localparam int tickW = $clog2(tickDiv);

	logic [tickW-1:0] tickCnt;
	logic tick;	// One clock wide
	gameStateT state;
	logic [15:0] waitCnt;	// Serve delay and win hold
	logic [1:0] paddlePhase;	// Four paddle ticks per ball step
	logic [1:0] hitCount;	// Speed-up on every fourth hit
	coordT ballX, ballY;
	coordT speedX, speedY;
	logic dirX;	// 1 moves right
	logic dirY;	// 1 moves down
	coordT leftPaddleY, rightPaddleY;
	playerT scorer;	// Who took the last point
	coordT ballMidY, ballRightX;
	logic leftHit, rightHit;

	// Deadzone, then clamp so the paddle stays on screen
	function automatic coordT mapPaddle(input potT pot);
		logic [8:0] doubled;
		coordT level;
		doubled = {pot, 1'b0};
		if (doubled < 9'(potDeadzone))
			level = '0;
		else
		begin
			level = coordT'(doubled) - coordT'(potDeadzone);
			if (level > coordT'(paddleMaxY))
				level = coordT'(paddleMaxY);
		end
		return level;
	endfunction

	//////////////////////////////////////////////////
	// Game tick
	//////////////////////////////////////////////////
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
			tickCnt <= '0;
		else if (tick)
			tickCnt <= '0;
		else
			tickCnt <= tickCnt + tickW'(1);
	end

	assign tick = (tickCnt == tickW'(tickDiv - 1));

	// Collision points, left edge and right edge at mid height
	assign ballMidY = ballY + coordT'(ballSize / 2);
	assign ballRightX = ballX + coordT'(ballSize);

	rectHit u_leftHit
	(
		.pointX(ballX),
		.pointY(ballMidY),
		.rectX(coordT'(leftPaddleX)),
		.rectY(leftPaddleY),
		.rectW(coordT'(paddleW)),
		.rectH(coordT'(paddleH)),
		.hit(leftHit)
	);

	rectHit u_rightHit
	(
		.pointX(ballRightX),
		.pointY(ballMidY),
		.rectX(coordT'(rightPaddleX)),
		.rectY(rightPaddleY),
		.rectW(coordT'(paddleW)),
		.rectH(coordT'(paddleH)),
		.hit(rightHit)
	);

	//////////////////////////////////////////////////
	// Game FSM
	//////////////////////////////////////////////////
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			state <= sIdle;
			waitCnt <= '0;
			paddlePhase <= '0;
			hitCount <= '0;
			ballX <= coordT'(serveX);
			ballY <= coordT'(serveY);
			speedX <= coordT'(startSpeed);
			speedY <= coordT'(startSpeed);
			dirX <= 1'b1;
			dirY <= 1'b1;
			leftPaddleY <= '0;
			rightPaddleY <= '0;
			scorer <= noPlayer;
			leftScore <= '0;
			rightScore <= '0;
			winner <= noPlayer;
		end
		else if (tick)
		begin
			case (state)
				sIdle:
				begin
					// Park the ball for the first serve
					ballX <= coordT'(serveX);
					ballY <= coordT'(serveY);
					dirX <= 1'b1;
					dirY <= 1'b1;
					speedX <= coordT'(startSpeed);
					speedY <= coordT'(startSpeed);
					hitCount <= '0;
					paddlePhase <= '0;
					waitCnt <= '0;
					if (startBtn)
					begin
						leftScore <= '0;	// Fresh match
						rightScore <= '0;
						state <= sServeWait;
					end
				end
				sServeWait:
				begin
					if (waitCnt == 16'(serveDelay - 1))
					begin
						waitCnt <= '0;
						state <= sPaddles;
					end
					else
						waitCnt <= waitCnt + 16'd1;
				end
				sPaddles:
				begin
					leftPaddleY <= mapPaddle(leftPot);
					rightPaddleY <= mapPaddle(rightPot);
					paddlePhase <= paddlePhase + 2'd1;
					if (paddlePhase == 2'd3)	// Fourth paddle tick
						state <= sBall;
				end
				sBall:
				begin
					ballX <= dirX ? ballX + speedX : ballX - speedX;
					ballY <= dirY ? ballY + speedY : ballY - speedY;
					state <= sCheck;
				end
				sCheck:
				begin
					// Later rules override earlier ones
					state <= sPaddles;
					if (ballX < speedX)	// Left goal
					begin
						scorer <= rightPlayer;
						state <= sScore;
					end
					if (ballX >= coordT'(goalRightX))	// Right goal
					begin
						scorer <= leftPlayer;
						state <= sScore;
					end
					if (ballY < speedY)
						dirY <= 1'b1;	// Off the ceiling
					if (ballY >= coordT'(floorY))
						dirY <= 1'b0;	// Off the floor
					if (leftHit)
						dirX <= 1'b1;
					if (rightHit)
						dirX <= 1'b0;
					if (leftHit || rightHit)
					begin
						hitCount <= hitCount + 2'd1;
						if (hitCount == 2'd3)
						begin
							speedX <= speedX + coordT'(1);
							speedY <= speedY + coordT'(1);
						end
					end
				end
				sScore:
				begin
					// Slow serve from the centre
					ballX <= coordT'(serveX);
					ballY <= coordT'(serveY);
					dirY <= 1'b1;
					speedX <= coordT'(serveSpeed);
					speedY <= coordT'(serveSpeed);
					hitCount <= '0;
					paddlePhase <= '0;
					waitCnt <= '0;
					state <= sServeWait;
					if (scorer == leftPlayer)
					begin
						dirX <= 1'b1;	// Toward the side that conceded
						leftScore <= leftScore + scoreT'(1);
						if (leftScore + scoreT'(1) == scoreT'(winScore))
						begin
							winner <= leftPlayer;
							state <= sWin;
						end
					end
					else
					begin
						dirX <= 1'b0;
						rightScore <= rightScore + scoreT'(1);
						if (rightScore + scoreT'(1) == scoreT'(winScore))
						begin
							winner <= rightPlayer;
							state <= sWin;
						end
					end
				end
				sWin:
				begin
					if (waitCnt == 16'(winHold - 1))
					begin
						leftScore <= '0;
						rightScore <= '0;
						winner <= noPlayer;
						waitCnt <= '0;
						state <= sIdle;
					end
					else
						waitCnt <= waitCnt + 16'd1;	// Result stays on screen
				end
				default:
					state <= sIdle;
			endcase
		end
	end

	// Scene for the renderer
	always_comb
	begin
		scene.ballX = ballX;
		scene.ballY = ballY;
		scene.leftPaddleY = leftPaddleY;
		scene.rightPaddleY = rightPaddleY;
		scene.leftScore = leftScore;
		scene.rightScore = rightScore;
		scene.playing = (state != sIdle);
		scene.colour = colourSw;	// Live from the switches
	end

endmodule

`default_nettype wire

/* hw/pixelRenderer.sv */
`timescale 1ns/100ps
`default_nettype none

module pixelRenderer import pongPkg::*;
(
	input wire DIV_CLK,
	input wire reset,
	input wire coordT pixelX,
	input wire coordT pixelY,
	input wire inDisplay,
	input wire hSyncRaw,
	input wire vSyncRaw,
	input wire sceneT scene,
	output logic hSync,
	output logic vSync,
	output pixelT rgb
);

	logic ballHit;
	logic leftPadHit, rightPadHit;
	logic leftDigitHit, rightDigitHit;
	logic borderHit;
	coordT dashRow;	// Index of 10-row group
	pixelT nextRgb;

	//////////////////////////////////////////////////
	// Object tests for the current pixel
	//////////////////////////////////////////////////
	rectHit u_ballDraw
	(
		.pointX(pixelX),
		.pointY(pixelY),
		.rectX(scene.ballX),
		.rectY(scene.ballY),
		.rectW(coordT'(ballSize)),
		.rectH(coordT'(ballSize)),
		.hit(ballHit)
	);

	rectHit u_leftPadDraw
	(
		.pointX(pixelX),
		.pointY(pixelY),
		.rectX(coordT'(leftPaddleX)),
		.rectY(scene.leftPaddleY),
		.rectW(coordT'(paddleW)),
		.rectH(coordT'(paddleH)),
		.hit(leftPadHit)
	);

	rectHit u_rightPadDraw
	(
		.pointX(pixelX),
		.pointY(pixelY),
		.rectX(coordT'(rightPaddleX)),
		.rectY(scene.rightPaddleY),
		.rectW(coordT'(paddleW)),
		.rectH(coordT'(paddleH)),
		.hit(rightPadHit)
	);

	scoreDigit u_leftDigit
	(
		.pixelX(pixelX),
		.pixelY(pixelY),
		.originX(coordT'(leftDigitX)),
		.value(scene.leftScore),
		.hit(leftDigitHit)
	);

	scoreDigit u_rightDigit
	(
		.pixelX(pixelX),
		.pixelY(pixelY),
		.originX(coordT'(rightDigitX)),
		.value(scene.rightScore),
		.hit(rightDigitHit)
	);

	// Dotted centre line, drawn on even groups
	assign dashRow = coordT'(pixelY / dashLen);
	assign borderHit = (pixelX >= coordT'(borderX)) &&
		(pixelX < coordT'(borderX + borderW)) && !dashRow[0];

	// Every object shares the switch colour
	always_comb
	begin
		nextRgb = '0;	// Idle, blanking or background
		if (scene.playing && inDisplay && (ballHit || leftPadHit || rightPadHit ||
			leftDigitHit || rightDigitHit || borderHit))
			nextRgb = scene.colour;
	end

	//////////////////////////////////////////////////
	// Output stage, colour and sync stay aligned
	//////////////////////////////////////////////////
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			hSync <= 1'b1;
			vSync <= 1'b1;
			rgb <= '0;
		end
		else
		begin
			hSync <= hSyncRaw;
			vSync <= vSyncRaw;
			rgb <= nextRgb;
		end
	end

endmodule

`default_nettype wire

/* hw/pongTop.sv */
`timescale 1ns/100ps
`default_nettype none

module pongTop import pongPkg::*;
#(
	parameter int tickDiv = 65536,
	parameter int serveDelay = 400,
	parameter int winHold = 4000
)
(
	input wire DIV_CLK,	// Pixel clock
	input wire reset,
	input wire potT leftPot,
	input wire potT rightPot,
	input wire startBtn,
	input wire pixelT colourSw,
	output logic hSync,
	output logic vSync,
	output pixelT rgb,
	output scoreT leftScore,
	output scoreT rightScore,
	output playerT winner
);

	coordT pixelX, pixelY;
	logic inDisplay;
	logic hSyncRaw, vSyncRaw;	// Unregistered, one clock ahead of rgb
	sceneT scene;

	vgaSyncGen u_vgaSyncGen
	(
		.DIV_CLK(DIV_CLK),
		.reset(reset),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.inDisplay(inDisplay),
		.hSyncRaw(hSyncRaw),
		.vSyncRaw(vSyncRaw)
	);

	gameController #(
		.tickDiv(tickDiv),
		.serveDelay(serveDelay),
		.winHold(winHold)
	) u_gameController
	(
		.DIV_CLK(DIV_CLK),
		.reset(reset),
		.leftPot(leftPot),
		.rightPot(rightPot),
		.startBtn(startBtn),
		.colourSw(colourSw),
		.scene(scene),
		.leftScore(leftScore),
		.rightScore(rightScore),
		.winner(winner)
	);

	pixelRenderer u_pixelRenderer
	(
		.DIV_CLK(DIV_CLK),
		.reset(reset),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.inDisplay(inDisplay),
		.hSyncRaw(hSyncRaw),
		.vSyncRaw(vSyncRaw),
		.scene(scene),
		.hSync(hSync),
		.vSync(vSync),
		.rgb(rgb)
	);

endmodule

`default_nettype wire

/* verif/pongTop_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module pongTopAssertions import pongPkg::*;
(
	input wire DIV_CLK,
	input wire reset,
	input wire hSync,
	input wire pixelT rgb,
	input wire scoreT leftScore,
	input wire scoreT rightScore,
	input wire playerT winner
);

	// Nothing lit during horizontal sync
	assert property (@(posedge DIV_CLK) disable iff (reset) !hSync |-> rgb == '0)
		else $error("rgb nonzero while hSync low");

	// Score steps by one or clears
	assert property (@(posedge DIV_CLK) disable iff (reset)
		leftScore != $past(leftScore) |->
		(leftScore == $past(leftScore) + scoreT'(1)) || (leftScore == '0))
		else $error("leftScore jumped");
	assert property (@(posedge DIV_CLK) disable iff (reset)
		rightScore != $past(rightScore) |->
		(rightScore == $past(rightScore) + scoreT'(1)) || (rightScore == '0))
		else $error("rightScore jumped");

	assert property (@(posedge DIV_CLK) disable iff (reset) winner != noPlayer |->
		(leftScore == scoreT'(winScore)) || (rightScore == scoreT'(winScore)))
		else $error("winner without a winning score");

endmodule

bind pongTop pongTopAssertions u_assertions (.*);

`default_nettype wire

/* verif/pongTb.sv */
`timescale 1ns/100ps
`default_nettype none

module pongTb import pongPkg::*;
();

	logic DIV_CLK;
	logic reset;
	potT leftPot, rightPot;
	logic startBtn;
	pixelT colourSw;
	wire hSync, vSync;
	pixelT rgb;
	scoreT leftScore, rightScore;
	playerT winner;

	int errors;
	int trackX, trackY;	// Pixel position seen on the outputs
	logic hValid, vValid, prevH, prevV;
	logic playActive;	// Game running, centre line visible
	int centreChecks;
	logic lit318;
	pixelT rgb319;
	pixelT colourV;
	// Game model
	int mBallX, mBallY, mSpeedX, mSpeedY, mDirX, mDirY, mHits;
	int mLeft, mRight;

	pongTop #(.tickDiv(4), .serveDelay(3), .winHold(5)) u_pongTop
	(
		.DIV_CLK(DIV_CLK),
		.reset(reset),
		.leftPot(leftPot),
		.rightPot(rightPot),
		.startBtn(startBtn),
		.colourSw(colourSw),
		.hSync(hSync),
		.vSync(vSync),
		.rgb(rgb),
		.leftScore(leftScore),
		.rightScore(rightScore),
		.winner(winner)
	);

	always #2 DIV_CLK = !DIV_CLK;	// 4 ns period

	task automatic checkValue(input string name, input int expected, input int actual);
		if (expected != actual)
		begin
			errors++;
			$display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic abortRun(input string what);
		$display("Timeout while %s", what);
		$display("Errors: %0d", errors + 1);
		$display("Done: errors found");
		$finish;
	endtask

	// Pot level to paddle top
	function automatic int paddleTop(input int pot);
		int level;
		level = pot * 2;
		if (level < 41)
			return 0;
		level = level - 41;
		return (level > 430) ? 430 : level;
	endfunction

	//////////////////////////////////////////////////
	// Rally model, returns 1 for left point, 2 for right
	//////////////////////////////////////////////////
	function automatic int predictPoint(input int lp, input int rp);
		int who, steps, midY, rightX;
		logic hitL, hitR;
		who = 0;
		for (steps = 0; steps < 100000 && who == 0; steps++)
		begin
			mBallX = (mDirX ? mBallX + mSpeedX : mBallX - mSpeedX) & 1023;
			mBallY = (mDirY ? mBallY + mSpeedY : mBallY - mSpeedY) & 1023;
			if (mBallX < mSpeedX)
				who = 2;
			if (mBallX >= 630)
				who = 1;
			if (mBallY < mSpeedY)
				mDirY = 1;	// Ceiling
			if (mBallY >= 470)
				mDirY = 0;	// Floor
			midY = (mBallY + 5) & 1023;
			rightX = (mBallX + 10) & 1023;
			hitL = mBallX >= 40 && mBallX < 50 && midY >= lp && midY < lp + 50;
			hitR = rightX >= 600 && rightX < 610 && midY >= rp && midY < rp + 50;
			if (hitL)
				mDirX = 1;
			if (hitR)
				mDirX = 0;
			if (hitL || hitR)
			begin
				if (mHits == 3)
				begin
					mSpeedX++;
					mSpeedY++;
				end
				mHits = (mHits + 1) % 4;
			end
		end
		return who;
	endfunction

	//////////////////////////////////////////////////
	// Position tracking from sync edges, pixel checks
	//////////////////////////////////////////////////
	always @(negedge DIV_CLK)
	begin
		if (reset)
		begin
			hValid = 1'b0;
			vValid = 1'b0;
			prevH = 1'b1;
			prevV = 1'b1;
		end
		else
		begin
			if (!hSync && prevH)
			begin
				trackX = 656;	// First low cycle
				hValid = 1'b1;
			end
			else
				trackX = (trackX + 1) % 800;
			if (hValid && trackX == 0)
				trackY = (trackY + 1) % 525;
			if (!vSync && prevV)
			begin
				trackY = 490;
				vValid = 1'b1;
			end
			prevH = hSync;
			prevV = vSync;
			if (hValid && vValid && (trackX >= 640 || trackY >= 480))
				checkValue("blanking", 0, rgb);
			if (hValid && vValid && playActive && trackY >= 100 && trackY <= 220)
			begin
				if (trackX == 318)
					lit318 = (rgb != 0);
				else if (trackX == 319)
					rgb319 = rgb;
				else if (trackX == 320)
				begin
					centreChecks++;
					if ((trackY / 10) % 2 == 0)
						checkValue("centre line dash", colourV, rgb319);
					else if (!lit318 && rgb == 0)	// No ball nearby
						checkValue("centre line gap", 0, rgb319);
				end
			end
		end
	end

	initial
	begin
		int i, hLow, vLow, who, lp, rp, prevL, prevR, limit;
		logic gameOver;
		errors = 0;
		centreChecks = 0;
		playActive = 1'b0;
		trackX = 0;
		trackY = 0;
		void'($urandom(32'h3168));
		DIV_CLK = 1'b0;
		reset = 1'b1;
		leftPot = '0;
		rightPot = '0;
		startBtn = 1'b0;
		colourSw = '0;
		repeat (16) @(posedge DIV_CLK);
		reset <= 1'b0;
		@(negedge DIV_CLK);
		checkValue("reset hSync", 1, hSync);
		checkValue("reset vSync", 1, vSync);
		checkValue("reset rgb", 0, rgb);
		checkValue("reset leftScore", 0, leftScore);
		checkValue("reset rightScore", 0, rightScore);
		checkValue("reset winner", noPlayer, winner);

		// One whole frame of sync
		hLow = 0;
		vLow = 0;
		for (i = 0; i < 800 * 525; i++)
		begin
			@(negedge DIV_CLK);
			hLow += !hSync;
			vLow += !vSync;
		end
		checkValue("hSync low cycles", 525 * 96, hLow);
		checkValue("vSync low cycles", 2 * 800, vLow);

		// Start just above the centre line window
		limit = 0;
		while (!(vValid && trackY == 95))
		begin
			@(posedge DIV_CLK);
			limit++;
			if (limit > 500000)
				abortRun("waiting for row 95");
		end
		colourV = pixelT'(($urandom % 255) + 1);
		lp = $urandom % 256;
		rp = $urandom % 256;
		colourSw <= colourV;
		leftPot <= potT'(lp);
		rightPot <= potT'(rp);
		startBtn <= 1'b1;
		repeat (8) @(posedge DIV_CLK);	// Two ticks
		startBtn <= 1'b0;
		playActive = 1'b1;
		mBallX = 315;
		mBallY = 235;
		mDirX = 1;
		mDirY = 1;
		mSpeedX = 2;
		mSpeedY = 2;
		mHits = 0;
		mLeft = 0;
		mRight = 0;
		prevL = 0;
		prevR = 0;
		gameOver = 1'b0;

		//////////////////////////////////////////////////
		// Rallies until a win
		//////////////////////////////////////////////////
		while (!gameOver)
		begin
			who = predictPoint(paddleTop(lp), paddleTop(rp));
			if (who == 0)
				abortRun("running the rally model");
			limit = 0;
			do
			begin
				@(negedge DIV_CLK);
				limit++;
				if (limit > 3000000)
					abortRun("waiting for a score change");
			end
			while (leftScore == prevL && rightScore == prevR);
			if (who == 1)
				mLeft++;
			else
				mRight++;
			checkValue("rally leftScore", mLeft, leftScore);
			checkValue("rally rightScore", mRight, rightScore);
			prevL = leftScore;
			prevR = rightScore;
			if (mLeft == 9 || mRight == 9)
			begin
				checkValue("winner", (who == 1) ? leftPlayer : rightPlayer, winner);
				gameOver = 1'b1;
				playActive = 1'b0;
			end
			else
			begin
				lp = $urandom % 256;	// New pots for the next rally
				rp = $urandom % 256;
				@(posedge DIV_CLK);
				leftPot <= potT'(lp);
				rightPot <= potT'(rp);
				mBallX = 315;
				mBallY = 235;
				mDirY = 1;
				mDirX = (who == 1) ? 1 : 0;
				mSpeedX = 1;
				mSpeedY = 1;
				mHits = 0;
			end
		end

		// Hold ends, scores clear
		limit = 0;
		while (leftScore != 0 || rightScore != 0)
		begin
			@(negedge DIV_CLK);
			limit++;
			if (limit > 1000)
				abortRun("waiting for the win hold to end");
		end
		checkValue("winner after hold", noPlayer, winner);
		for (i = 0; i < 200; i++)
		begin
			@(negedge DIV_CLK);
			checkValue("idle leftScore", 0, leftScore);
			checkValue("idle rightScore", 0, rightScore);
			checkValue("idle rgb", 0, rgb);	// Dark until started
		end
		if (centreChecks == 0)
		begin
			errors++;
			$display("Centre line rows were never shown during play");
		end

		$display("Errors: %0d, centre line rows checked: %0d", errors, centreChecks);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
hw/pongPkg.sv
hw/vgaSyncGen.sv
hw/rectHit.sv
hw/scoreDigit.sv
hw/gameController.sv
hw/pixelRenderer.sv
hw/pongTop.sv
verif/pongTop_assertions.sv
verif/pongTb.sv

/* Makefile */
# Verilator flow for the pong playfield core

TOP = pongTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f -o simv
	./obj_dir/simv > sim.log 2>&1 || true
	cat sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
